//--- src/axi_mem_pkg.sv
// axi memory slave shared widths, encodings and channel structs
`default_nettype none

package axi_mem_pkg;

  // ----------------------------------------
  // sizes
  // ----------------------------------------
  localparam int ADDR_W     = 4;
  localparam int DATA_W     = 32;
  // burst length field holds beats minus one
  localparam int LEN_W      = 4;
  localparam int MEM_DEPTH  = 16;
  localparam int WRAP_BEATS = 4;

  // ----------------------------------------
  // encodings
  // ----------------------------------------
  typedef enum logic [1:0] {
    BURST_FIXED    = 2'b00,
    BURST_INCR     = 2'b01,
    BURST_WRAP     = 2'b10,
    BURST_RESERVED = 2'b11
  } burst_e;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } resp_e;

  // ----------------------------------------
  // channel payloads
  // ----------------------------------------
  // used for both aw and ar
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [LEN_W-1:0]  len;
    burst_e            burst;
  } addr_req_t;

  // one read data beat
  typedef struct packed {
    logic [DATA_W-1:0] data;
    resp_e             resp;
    logic              last;
  } r_beat_t;

endpackage

`default_nettype wire

//--- src/axi_burst_addr.sv
// burst address generator with a beat counter and fixed, incr and wrap addressing
`default_nettype none

module axi_burst_addr (
  input  logic                            aclk,
  input  logic                            aresetn,
  input  logic                            start,
  input  axi_mem_pkg::addr_req_t          req,
  input  logic                            advance,
  output logic [axi_mem_pkg::ADDR_W-1:0]  addr,
  output logic                            last
);
  import axi_mem_pkg::*;

  addr_req_t         req_q;
  logic [LEN_W-1:0]  beat_cnt;
  logic [ADDR_W-1:0] wrap_off;

  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      req_q    <= '0;
      beat_cnt <= '0;
    end else if (start) begin
      req_q    <= req;
      beat_cnt <= '0;
    end else if (advance) begin
      beat_cnt <= beat_cnt + 1'b1;
    end
  end

  // wrap offset repeats every four beats
  assign wrap_off = ADDR_W'(beat_cnt % WRAP_BEATS);

  // sums truncate to ADDR_W, so the address rolls over the array
  always_comb begin
    case (req_q.burst)
      BURST_INCR: addr = req_q.addr + ADDR_W'(beat_cnt);
      BURST_WRAP: addr = req_q.addr + wrap_off;
      default:    addr = req_q.addr;
    endcase
  end

  assign last = (beat_cnt == req_q.len);

endmodule

`default_nettype wire

//--- src/axi_mem_array.sv
// word storage with a written flag per word, one write and one read port
`default_nettype none

module axi_mem_array (
  input  logic                            aclk,
  input  logic                            aresetn,
  input  logic                            we,
  input  logic [axi_mem_pkg::ADDR_W-1:0]  waddr,
  input  logic [axi_mem_pkg::DATA_W-1:0]  wdata,
  input  logic [axi_mem_pkg::ADDR_W-1:0]  raddr,
  output logic [axi_mem_pkg::DATA_W-1:0]  rdata,
  output logic                            rwritten
);
  import axi_mem_pkg::*;

  logic [DATA_W-1:0]    mem [MEM_DEPTH];
  logic [MEM_DEPTH-1:0] written;

  // data words
  always_ff @(posedge aclk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // flags cleared on reset, set by any write
  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      written <= '0;
    end else if (we) begin
      written[waddr] <= 1'b1;
    end
  end

  assign rdata    = mem[raddr];
  assign rwritten = written[raddr];

endmodule

`default_nettype wire

//--- src/axi_write_ctrl.sv
// write channel FSM that takes the aw request, writes w beats and returns the b response
`default_nettype none

module axi_write_ctrl (
  input  logic                            aclk,
  input  logic                            aresetn,
  input  axi_mem_pkg::addr_req_t          aw,
  input  logic                            awvalid,
  output logic                            awready,
  input  logic [axi_mem_pkg::DATA_W-1:0]  wdata,
  input  logic                            wvalid,
  output logic                            wready,
  output axi_mem_pkg::resp_e              bresp,
  output logic                            bvalid,
  input  logic                            bready,
  output logic                            mem_we,
  output logic [axi_mem_pkg::ADDR_W-1:0]  mem_waddr,
  output logic [axi_mem_pkg::DATA_W-1:0]  mem_wdata
);
  import axi_mem_pkg::*;

  typedef enum logic [1:0] {
    W_IDLE,
    W_DATA,
    W_RESP
  } wr_state_e;

  wr_state_e         state;
  wr_state_e         state_nxt;
  burst_e            burst_q;
  logic              aw_hs;
  logic              w_hs;
  logic              beat_last;
  logic [ADDR_W-1:0] beat_addr;

  // ----------------------------------------
  // handshakes
  // ----------------------------------------
  assign awready = (state == W_IDLE);
  assign wready  = (state == W_DATA);
  assign bvalid  = (state == W_RESP);
  assign aw_hs   = awvalid & awready;
  assign w_hs    = wvalid & wready;

  always_comb begin
    state_nxt = state;
    case (state)
      W_IDLE: if (aw_hs) state_nxt = W_DATA;
      W_DATA: if (w_hs && beat_last) state_nxt = W_RESP;
      W_RESP: if (bready) state_nxt = W_IDLE;
      default: state_nxt = W_IDLE;
    endcase
  end

  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      state   <= W_IDLE;
      burst_q <= BURST_FIXED;
    end else begin
      state <= state_nxt;
      if (aw_hs) begin
        burst_q <= aw.burst;
      end
    end
  end

  axi_burst_addr u_burst_addr (
    .aclk    (aclk),
    .aresetn (aresetn),
    .start   (aw_hs),
    .req     (aw),
    .advance (w_hs),
    .addr    (beat_addr),
    .last    (beat_last)
  );

  // reserved bursts still consume their beats but leave memory alone
  assign mem_we    = w_hs & (burst_q != BURST_RESERVED);
  assign mem_waddr = beat_addr;
  assign mem_wdata = wdata;
  assign bresp     = RESP_OKAY;

endmodule

`default_nettype wire

//--- src/axi_read_ctrl.sv
// read channel FSM that takes the ar request and returns registered r beats
`default_nettype none

module axi_read_ctrl (
  input  logic                            aclk,
  input  logic                            aresetn,
  input  axi_mem_pkg::addr_req_t          ar,
  input  logic                            arvalid,
  output logic                            arready,
  output axi_mem_pkg::r_beat_t            r,
  output logic                            rvalid,
  input  logic                            rready,
  output logic [axi_mem_pkg::ADDR_W-1:0]  mem_raddr,
  input  logic [axi_mem_pkg::DATA_W-1:0]  mem_rdata,
  input  logic                            mem_rwritten
);
  import axi_mem_pkg::*;

  typedef enum logic {
    R_IDLE,
    R_BEAT
  } rd_state_e;

  rd_state_e state;
  burst_e    burst_q;
  logic      ar_hs;
  logic      r_hs;
  logic      fetch;
  logic      beat_last;
  r_beat_t   beat;

  assign arready = (state == R_IDLE);
  assign ar_hs   = arvalid & arready;
  assign r_hs    = rvalid & rready;

  axi_burst_addr u_burst_addr (
    .aclk    (aclk),
    .aresetn (aresetn),
    .start   (ar_hs),
    .req     (ar),
    .advance (r_hs),
    .addr    (mem_raddr),
    .last    (beat_last)
  );

  // ----------------------------------------
  // beat lookup
  // ----------------------------------------
  always_comb begin
    beat.last = beat_last;
    if (mem_rwritten && (burst_q != BURST_RESERVED)) begin
      beat.data = mem_rdata;
      beat.resp = RESP_OKAY;
    end else begin
      beat.data = '0;
      beat.resp = RESP_SLVERR;
    end
  end

  // fetch runs one cycle behind the address or beat handshake
  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      state   <= R_IDLE;
      burst_q <= BURST_FIXED;
      fetch   <= 1'b0;
      rvalid  <= 1'b0;
    end else begin
      fetch <= ar_hs | (r_hs & ~r.last);
      if (ar_hs) begin
        state   <= R_BEAT;
        burst_q <= ar.burst;
      end else if (r_hs && r.last) begin
        state <= R_IDLE;
      end
      if (fetch) begin
        rvalid <= 1'b1;
      end else if (r_hs) begin
        rvalid <= 1'b0;
      end
    end
  end

  // payload only loads on fetch, so it holds under back-pressure
  always_ff @(posedge aclk) begin
    if (fetch) begin
      r <= beat;
    end
  end

endmodule

`default_nettype wire

//--- src/axi_mem_slave.sv
// axi memory slave top joining the write and read channel controllers to one word array
`default_nettype none

module axi_mem_slave (
  input  logic                            aclk,
  input  logic                            aresetn,
  // write address
  input  axi_mem_pkg::addr_req_t          aw,
  input  logic                            awvalid,
  output logic                            awready,
  // write data
  input  logic [axi_mem_pkg::DATA_W-1:0]  wdata,
  input  logic                            wvalid,
  output logic                            wready,
  // write response
  output axi_mem_pkg::resp_e              bresp,
  output logic                            bvalid,
  input  logic                            bready,
  // read address
  input  axi_mem_pkg::addr_req_t          ar,
  input  logic                            arvalid,
  output logic                            arready,
  // read data
  output axi_mem_pkg::r_beat_t            r,
  output logic                            rvalid,
  input  logic                            rready
);
  import axi_mem_pkg::*;

  logic              mem_we;
  logic [ADDR_W-1:0] mem_waddr;
  logic [DATA_W-1:0] mem_wdata;
  logic [ADDR_W-1:0] mem_raddr;
  logic [DATA_W-1:0] mem_rdata;
  logic              mem_rwritten;

  // ----------------------------------------
  // channel controllers
  // ----------------------------------------
  axi_write_ctrl u_write_ctrl (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .aw        (aw),
    .awvalid   (awvalid),
    .awready   (awready),
    .wdata     (wdata),
    .wvalid    (wvalid),
    .wready    (wready),
    .bresp     (bresp),
    .bvalid    (bvalid),
    .bready    (bready),
    .mem_we    (mem_we),
    .mem_waddr (mem_waddr),
    .mem_wdata (mem_wdata)
  );

  axi_read_ctrl u_read_ctrl (
    .aclk         (aclk),
    .aresetn      (aresetn),
    .ar           (ar),
    .arvalid      (arvalid),
    .arready      (arready),
    .r            (r),
    .rvalid       (rvalid),
    .rready       (rready),
    .mem_raddr    (mem_raddr),
    .mem_rdata    (mem_rdata),
    .mem_rwritten (mem_rwritten)
  );

  // shared storage
  axi_mem_array u_mem (
    .aclk     (aclk),
    .aresetn  (aresetn),
    .we       (mem_we),
    .waddr    (mem_waddr),
    .wdata    (mem_wdata),
    .raddr    (mem_raddr),
    .rdata    (mem_rdata),
    .rwritten (mem_rwritten)
  );

endmodule

`default_nettype wire

//--- verif/tb_axi_mem_slave.sv
// table-driven testbench for the axi memory slave with a word model and random stalls
`default_nettype none

module tb_axi_mem_slave;
  timeunit 1ns;
  timeprecision 100ps;

  import axi_mem_pkg::*;

  localparam int NUM_TX     = 14;
  localparam int CLK_PERIOD = 8;
  localparam int RST_CYC    = 16;
  localparam int HS_LIMIT   = 32;

  logic              aclk;
  logic              aresetn;
  addr_req_t         aw;
  logic              awvalid;
  logic              awready;
  logic [DATA_W-1:0] wdata;
  logic              wvalid;
  logic              wready;
  resp_e             bresp;
  logic              bvalid;
  logic              bready;
  addr_req_t         ar;
  logic              arvalid;
  logic              arready;
  r_beat_t           r;
  logic              rvalid;
  logic              rready;

  // transaction table
  string             tx_name  [NUM_TX];
  logic              tx_write [NUM_TX];
  addr_req_t         tx_req   [NUM_TX];
  logic [DATA_W-1:0] tx_base  [NUM_TX];
  int                n_tx;
  int                total_beats;

  // word model with written flags
  logic [DATA_W-1:0] model_mem     [MEM_DEPTH];
  logic              model_written [MEM_DEPTH];

  int value_errs;
  int protocol_errs;

  axi_mem_slave u_dut (.*);

  always #(CLK_PERIOD / 2) aclk = ~aclk;

  // ----------------------------------------
  // table and model helpers
  // ----------------------------------------
  task automatic add_tx(string name, logic is_write, burst_e burst, int addr, int len,
                        logic [DATA_W-1:0] base);
    addr_req_t req;
    req.addr        = ADDR_W'(addr);
    req.len         = LEN_W'(len);
    req.burst       = burst;
    tx_name[n_tx]   = name;
    tx_write[n_tx]  = is_write;
    tx_req[n_tx]    = req;
    tx_base[n_tx]   = base;
    total_beats     = total_beats + len + 1;
    n_tx            = n_tx + 1;
  endtask

  // wrap bursts repeat a four-word window and every address rolls over the array
  function automatic logic [ADDR_W-1:0] beat_address(addr_req_t req, int k);
    int off;
    case (req.burst)
      BURST_INCR: off = k;
      BURST_WRAP: off = k % WRAP_BEATS;
      default:    off = 0;
    endcase
    return ADDR_W'(int'(req.addr) + off);
  endfunction

  function automatic logic is_high(string sig);
    case (sig)
      "awready": return awready;
      "wready":  return wready;
      "bvalid":  return bvalid;
      "arready": return arready;
      default:   return rvalid;
    endcase
  endfunction

  // polls on falling edges until the signal is high or the limit runs out
  task automatic await_signal(string name, string sig);
    int n;
    n = 0;
    while (!is_high(sig) && n < HS_LIMIT) begin
      @(negedge aclk);
      n++;
    end
    if (!is_high(sig)) begin
      $display("%s: %s stayed low for %0d cycles, handshake missing", name, sig, HS_LIMIT);
      protocol_errs++;
    end
  endtask

  // both channels back in idle
  task automatic verify_idle(string when);
    if (!(awready && arready && !wready && !bvalid && !rvalid)) begin
      $display("handshake outputs are not at their idle values %s", when);
      protocol_errs++;
    end
  endtask

  task automatic check_resp(string name, resp_e exp, resp_e act);
    if (act !== exp) begin
      $display("** Error %s: bresp expected %b, actual %b", name, exp, act);
      value_errs++;
    end
  endtask

  // fields shown as data/resp/last
  task automatic check_beat(string name, int k, r_beat_t exp, r_beat_t act);
    if (act !== exp) begin
      $display("** Error %s beat %0d: expected %h/%b/%b, actual %h/%b/%b",
               name, k, exp.data, exp.resp, exp.last, act.data, act.resp, act.last);
      value_errs++;
    end
  endtask

  // ----------------------------------------
  // bursts
  // ----------------------------------------
  task automatic write_burst(int idx);
    addr_req_t         req;
    logic [ADDR_W-1:0] a;
    int                k;
    int                stall;
    req     = tx_req[idx];
    aw      = req;
    awvalid = 1'b1;
    await_signal(tx_name[idx], "awready");
    @(negedge aclk);
    awvalid = 1'b0;
    for (k = 0; k <= req.len; k++) begin
      wdata  = tx_base[idx] + k;
      wvalid = 1'b1;
      await_signal(tx_name[idx], "wready");
      @(negedge aclk);
      if (req.burst != BURST_RESERVED) begin
        a                = beat_address(req, k);
        model_mem[a]     = tx_base[idx] + k;
        model_written[a] = 1'b1;
      end
    end
    wvalid = 1'b0;
    stall  = $urandom % 4;
    repeat (stall) @(negedge aclk);
    bready = 1'b1;
    await_signal(tx_name[idx], "bvalid");
    check_resp(tx_name[idx], RESP_OKAY, bresp);
    @(negedge aclk);
    bready = 1'b0;
  endtask

  task automatic read_burst(int idx);
    addr_req_t         req;
    r_beat_t           exp;
    logic [ADDR_W-1:0] a;
    int                k;
    int                stall;
    req     = tx_req[idx];
    ar      = req;
    arvalid = 1'b1;
    await_signal(tx_name[idx], "arready");
    @(negedge aclk);
    arvalid = 1'b0;
    for (k = 0; k <= req.len; k++) begin
      a = beat_address(req, k);
      // unwritten words and reserved bursts read as zero with slverr
      if (model_written[a] && req.burst != BURST_RESERVED) begin
        exp.data = model_mem[a];
        exp.resp = RESP_OKAY;
      end else begin
        exp.data = '0;
        exp.resp = RESP_SLVERR;
      end
      exp.last = (k == req.len);
      stall    = $urandom % 4;
      repeat (stall) @(negedge aclk);
      rready = 1'b1;
      await_signal(tx_name[idx], "rvalid");
      check_beat(tx_name[idx], k, exp, r);
      @(negedge aclk);
      rready = 1'b0;
    end
  endtask

  // ----------------------------------------
  // main sequence
  // ----------------------------------------
  initial begin
    int i;
    void'($urandom(32'hf4d8_8131));
    aclk    = 1'b0;
    aresetn = 1'b0;
    aw      = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    ar      = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    for (i = 0; i < MEM_DEPTH; i++) begin
      model_written[i] = 1'b0;
    end
    add_tx("rd_empty_incr",     1'b0, BURST_INCR,     0,  3, 32'h0);
    add_tx("wr_incr_roll",      1'b1, BURST_INCR,     12, 5, 32'h1000_0000);
    add_tx("rd_incr_roll",      1'b0, BURST_INCR,     12, 5, 32'h0);
    add_tx("wr_fixed",          1'b1, BURST_FIXED,    10, 3, 32'h2000_0000);
    add_tx("rd_fixed",          1'b0, BURST_FIXED,    10, 2, 32'h0);
    add_tx("rd_fixed_nbrs",     1'b0, BURST_INCR,     9,  2, 32'h0);
    add_tx("wr_wrap",           1'b1, BURST_WRAP,     5,  7, 32'h3000_0000);
    add_tx("rd_wrap",           1'b0, BURST_WRAP,     5,  7, 32'h0);
    add_tx("rd_wrap_span",      1'b0, BURST_INCR,     4,  5, 32'h0);
    add_tx("wr_reserved",       1'b1, BURST_RESERVED, 3,  2, 32'h4000_0000);
    add_tx("rd_after_reserved", 1'b0, BURST_INCR,     3,  2, 32'h0);
    add_tx("rd_reserved",       1'b0, BURST_RESERVED, 12, 3, 32'h0);
    add_tx("wr_incr_full",      1'b1, BURST_INCR,     0, 15, 32'h5000_0000);
    add_tx("rd_incr_full",      1'b0, BURST_INCR,     0, 15, 32'h0);

    repeat (RST_CYC) @(posedge aclk);
    @(negedge aclk);
    aresetn = 1'b1;
    @(negedge aclk);
    verify_idle("after reset");

    for (i = 0; i < n_tx; i++) begin
      if (tx_write[i]) begin
        write_burst(i);
      end else begin
        read_burst(i);
      end
    end
    verify_idle("after the last burst");

    $display("errors: %0d value mismatches, %0d handshake failures",
             value_errs, protocol_errs);
    if (value_errs + protocol_errs == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  // watchdog allows sixteen cycles per table beat plus reset
  initial begin
    wait (n_tx == NUM_TX);
    #((total_beats * 16 + RST_CYC) * CLK_PERIOD);
    $display("timeout: bursts still running after %0d cycles", total_beats * 16 + RST_CYC);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
src/axi_mem_pkg.sv
src/axi_burst_addr.sv
src/axi_mem_array.sv
src/axi_write_ctrl.sv
src/axi_read_ctrl.sv
src/axi_mem_slave.sv
verif/tb_axi_mem_slave.sv

//--- Bender.yml
package:
  name: axi_mem_slave

sources:
  - src/axi_mem_pkg.sv
  - src/axi_burst_addr.sv
  - src/axi_mem_array.sv
  - src/axi_write_ctrl.sv
  - src/axi_read_ctrl.sv
  - src/axi_mem_slave.sv
  - target: test
    files:
      - verif/tb_axi_mem_slave.sv
